//--- src/nocPkg.sv
package nocPkg;

  // Router geometry inside a 4 by 4 mesh
  localparam int numPorts = 5;
  localparam int coordW = 2;

  // Own coordinates of this router
  localparam logic [coordW-1:0] routerX = 2'd1;
  localparam logic [coordW-1:0] routerY = 2'd1;

  // Entries held by each input queue
  localparam int queueDepth = 4;

  // Port order also sets the grant bit order, grant bit 0 being idle
  typedef enum logic [2:0] {
    portLocal,
    portNorth,
    portEast,
    portWest,
    portSouth
  } portE;

  typedef enum logic [1:0] {
    kindHead,
    kindBody,
    kindTail
  } flitKindE;

  // Length is only meaningful in a head flit
  typedef struct packed {
    flitKindE          kind;
    logic [coordW-1:0] destX;
    logic [coordW-1:0] destY;
    logic [11:0]       length;
    logic [15:0]       payload;
  } flitT;

endpackage

//--- src/flitQueue.sv
`timescale 1ns/1ps

module flitQueue (
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT pushFlit,
  input  logic         pushValid,
  output logic         pushReady,
  output nocPkg::flitT headFlit,
  output logic         headValid,
  input  logic         pop
);

  import nocPkg::*;

  flitT                          mem [queueDepth];
  logic [$clog2(queueDepth)-1:0] rdPtr;
  logic [$clog2(queueDepth)-1:0] wrPtr;
  logic [$clog2(queueDepth):0]   count;
  logic [$clog2(queueDepth):0]   countNext;
  logic                          pushOk;
  logic                          popOk;

  assign pushOk = pushValid && pushReady;
  assign popOk = pop && headValid;

  assign headValid = (count != '0);
  assign headFlit = mem[rdPtr];

  always_comb
  begin
    case ({pushOk, popOk})
      2'b10:   countNext = count + 1'b1;
      2'b01:   countNext = count - 1'b1;
      default: countNext = count;
    endcase
  end

  // Ready is registered so that it stays low while reset is applied
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
      pushReady <= 1'b0;
    end
    else
    begin
      count <= countNext;
      pushReady <= (countNext != queueDepth);
      if (pushOk)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (popOk)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pushOk)
    begin
      mem[wrPtr] <= pushFlit;
    end
  end

endmodule

//--- src/xyRoute.sv
`timescale 1ns/1ps

module xyRoute (
  input  nocPkg::flitT headFlit,
  output nocPkg::portE routePort
);

  import nocPkg::*;

  // X is resolved first and Y grows toward the South port
  always_comb
  begin
    if (headFlit.destX > routerX)
    begin
      routePort = portEast;
    end
    else if (headFlit.destX < routerX)
    begin
      routePort = portWest;
    end
    else if (headFlit.destY > routerY)
    begin
      routePort = portSouth;
    end
    else if (headFlit.destY < routerY)
    begin
      routePort = portNorth;
    end
    else
    begin
      routePort = portLocal;
    end
  end

endmodule

//--- src/holdTimer.sv
`timescale 1ns/1ps

module holdTimer (
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT headFlit,
  input  logic         running,
  input  logic         moved,
  output logic         timeUp
);

  import nocPkg::*;

  logic [11:0] budget;
  logic [11:0] count;
  logic        armed;

  always_ff @(posedge clk)
  begin
    if (rst || !running)
    begin
      armed <= 1'b0;
      budget <= '0;
      count <= '0;
    end
    else
    begin
      armed <= 1'b1;
      // Budget is taken once per grant, and only a head flit carries one
      if (!armed)
      begin
        budget <= (headFlit.kind == kindHead) ? headFlit.length : '0;
      end
      if (moved)
      begin
        count <= count + 1'b1;
      end
    end
  end

  // Zero budget never expires
  assign timeUp = (budget != '0) && (count == budget);

endmodule

//--- src/switchArbiter.sv
`timescale 1ns/1ps

module switchArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::numPorts-1:0] request,
  input  nocPkg::flitT                headFlit [nocPkg::numPorts],
  input  logic                        moved,
  output logic [nocPkg::numPorts:0]   grant
);

  import nocPkg::*;

  logic [numPorts:0]   grantQ;
  logic [numPorts:0]   grantNext;
  logic [numPorts-1:0] running;
  logic [numPorts-1:0] timeUp;
  logic                holdValid;
  portE                holder;
  logic                keep;
  int                  searchStart;
  int                  searchIdx;

  // Each input has a timer that runs only while that input holds the grant
  for (genvar i = 0; i < numPorts; i++)
  begin : genTimer
    assign running[i] = grantQ[i + 1] && !timeUp[i];

    holdTimer timer (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[i]),
      .running  (running[i]),
      .moved    (moved && grantQ[i + 1]),
      .timeUp   (timeUp[i])
    );
  end

  always_comb
  begin
    holdValid = 1'b0;
    holder = portLocal;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grantQ[i + 1])
      begin
        holdValid = 1'b1;
        holder = portE'(i);
      end
    end
  end

  assign keep = holdValid && request[holder] && !timeUp[holder];

  // Rotating search begins just past the holder and wraps around
  always_comb
  begin
    searchStart = 0;
    searchIdx = 0;
    if (holdValid && (int'(holder) != numPorts - 1))
    begin
      searchStart = int'(holder) + 1;
    end

    grantNext = {{numPorts{1'b0}}, 1'b1};
    if (keep)
    begin
      grantNext = grantQ;
    end
    else
    begin
      // Walk backwards so the nearest requester is the last one written
      for (int k = numPorts - 1; k >= 0; k--)
      begin
        searchIdx = searchStart + k;
        if (searchIdx >= numPorts)
        begin
          searchIdx = searchIdx - numPorts;
        end
        if (request[searchIdx])
        begin
          grantNext = '0;
          grantNext[searchIdx + 1] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantQ <= {{numPorts{1'b0}}, 1'b1};
    end
    else
    begin
      grantQ <= grantNext;
    end
  end

  // A holder that ran dry or out of budget is shown as idle until the
  // register moves on, so no stale head is forwarded
  assign grant = keep ? grantQ : {{numPorts{1'b0}}, 1'b1};

endmodule

//--- src/crossbar.sv
`timescale 1ns/1ps

module crossbar (
  input  logic [nocPkg::numPorts:0]   grant [nocPkg::numPorts],
  input  nocPkg::flitT                headFlit [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] outReady,
  output nocPkg::flitT                outFlit [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] outValid,
  output logic [nocPkg::numPorts-1:0] popReady,
  output logic [nocPkg::numPorts-1:0] moved
);

  import nocPkg::*;

  // One-hot select per output
  always_comb
  begin
    for (int o = 0; o < numPorts; o++)
    begin
      outFlit[o] = '0;
      outValid[o] = 1'b0;
      for (int i = 0; i < numPorts; i++)
      begin
        if (grant[o][i + 1])
        begin
          outFlit[o] = headFlit[i];
          outValid[o] = 1'b1;
        end
      end
      moved[o] = outValid[o] && outReady[o];
    end
  end

  // An input pops only when the output granting it is ready
  always_comb
  begin
    popReady = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      for (int o = 0; o < numPorts; o++)
      begin
        if (grant[o][i + 1] && outReady[o])
        begin
          popReady[i] = 1'b1;
        end
      end
    end
  end

endmodule

//--- src/meshRouter.sv
`timescale 1ns/1ps

module meshRouter (
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::flitT                inFlit [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] inValid,
  output logic [nocPkg::numPorts-1:0] inReady,
  output nocPkg::flitT                outFlit [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] outValid,
  input  logic [nocPkg::numPorts-1:0] outReady
);

  import nocPkg::*;

  flitT                headFlit [numPorts];
  logic [numPorts-1:0] headValid;
  portE                routePort [numPorts];
  logic [numPorts-1:0] request [numPorts];
  logic [numPorts:0]   grant [numPorts];
  logic [numPorts-1:0] popReady;
  logic [numPorts-1:0] moved;

  for (genvar p = 0; p < numPorts; p++)
  begin : genInput
    flitQueue queue (
      .clk       (clk),
      .rst       (rst),
      .pushFlit  (inFlit[p]),
      .pushValid (inValid[p]),
      .pushReady (inReady[p]),
      .headFlit  (headFlit[p]),
      .headValid (headValid[p]),
      .pop       (popReady[p])
    );

    xyRoute route (
      .headFlit  (headFlit[p]),
      .routePort (routePort[p])
    );
  end

  for (genvar o = 0; o < numPorts; o++)
  begin : genOutput
    // An input asks for this output when its head is routed here
    for (genvar i = 0; i < numPorts; i++)
    begin : genRequest
      assign request[o][i] = headValid[i] && (routePort[i] == portE'(o));
    end

    switchArbiter arbiter (
      .clk      (clk),
      .rst      (rst),
      .request  (request[o]),
      .headFlit (headFlit),
      .moved    (moved[o]),
      .grant    (grant[o])
    );
  end

  crossbar xbar (
    .grant    (grant),
    .headFlit (headFlit),
    .outReady (outReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .popReady (popReady),
    .moved    (moved)
  );

endmodule

//--- testbench/routerTb.sv
`timescale 1ns/1ps

module routerTb;

  import nocPkg::*;

  logic                clk;
  logic                rst;
  flitT                inFlit [numPorts];
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0] inReady;
  flitT                outFlit [numPorts];
  logic [numPorts-1:0] outValid;
  logic [numPorts-1:0] outReady;

  // Lines of the stimulus file are kept in file order
  flitT stimFlit [$];
  int   stimTest [$];
  int   stimIn [$];
  int   stimOut [$];

  // Index of the next flit to send per input and to expect per output
  int                  inIdx [numPorts];
  int                  outIdx [numPorts];
  logic [numPorts-1:0] prevStall;
  flitT                prevFlit [numPorts];
  logic [31:0]         randomBits;
  int                  curTest;
  int                  errors;
  int                  checks;
  int                  testsRun;

  meshRouter dut0 (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outReady (outReady)
  );

  always #20 clk = ~clk;

  function automatic int nextEntry(input int from, input int testNum, input int port,
                                   input bit byOutput);
    for (int k = from; k < stimFlit.size(); k++)
    begin
      if (stimTest[k] == testNum && (byOutput ? stimOut[k] : stimIn[k]) == port)
      begin
        return k;
      end
    end
    return -1;
  endfunction

  function automatic bit pending();
    bit busy;
    busy = 1'b0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (inIdx[p] >= 0 || outIdx[p] >= 0)
      begin
        busy = 1'b1;
      end
    end
    return busy;
  endfunction

  task automatic readStim();
    int    fd;
    int    n;
    string line;
    int    testNum;
    int    inPort;
    int    outPort;
    int    dx;
    int    dy;
    int    kind;
    int    len;
    int    payload;
    flitT  f;
    fd = $fopen("testbench/routerStim.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file testbench/routerStim.txt");
      errors++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#")
      begin
        n = $sscanf(line, "%d %d %h %h %d %h %h %d", testNum, inPort, dx, dy, kind, len,
                    payload, outPort);
        if (n != 8)
        begin
          $display("Stimulus line could not be parsed: %s", line);
          errors++;
        end
        else
        begin
          f.kind = flitKindE'(kind[1:0]);
          f.destX = dx[coordW-1:0];
          f.destY = dy[coordW-1:0];
          f.length = len[11:0];
          f.payload = payload[15:0];
          stimFlit.push_back(f);
          stimTest.push_back(testNum);
          stimIn.push_back(inPort);
          stimOut.push_back(outPort);
        end
      end
    end
    $fclose(fd);
  endtask

  // Compares every transfer of the cycle that ends at this edge
  task automatic checkOutputs();
    for (int o = 0; o < numPorts; o++)
    begin
      if (prevStall[o])
      begin
        checks++;
        if (!outValid[o])
        begin
          $display("Output %0d dropped its valid flit at %0t while stalled", o, $time);
          errors++;
        end
        else if (outFlit[o] !== prevFlit[o])
        begin
          $display("Mismatch at %0t: outFlit[%0d] expected %h, got %h", $time, o,
                   prevFlit[o], outFlit[o]);
          errors++;
        end
      end
      if (outValid[o] && outReady[o])
      begin
        checks++;
        if (outIdx[o] < 0)
        begin
          $display("Output %0d sent flit %h at %0t when none was expected", o,
                   outFlit[o], $time);
          errors++;
        end
        else
        begin
          if (outFlit[o] !== stimFlit[outIdx[o]])
          begin
            $display("Mismatch at %0t: outFlit[%0d] expected %h, got %h", $time, o,
                     stimFlit[outIdx[o]], outFlit[o]);
            errors++;
          end
          outIdx[o] = nextEntry(outIdx[o] + 1, curTest, o, 1'b1);
        end
      end
      prevStall[o] = outValid[o] && !outReady[o];
      prevFlit[o] = outFlit[o];
    end
  endtask

  task automatic driveInputs();
    for (int p = 0; p < numPorts; p++)
    begin
      if (inValid[p] && inReady[p])
      begin
        inIdx[p] = nextEntry(inIdx[p] + 1, curTest, p, 1'b0);
      end
      if (inIdx[p] >= 0)
      begin
        inFlit[p] <= stimFlit[inIdx[p]];
        inValid[p] <= 1'b1;
      end
      else
      begin
        inValid[p] <= 1'b0;
      end
    end
    randomBits = $urandom;
    outReady <= (curTest == 6) ? randomBits[numPorts-1:0] : {numPorts{1'b1}};
  endtask

  task automatic checkReset();
    int cycles;
    int errorsBefore;
    errorsBefore = errors;
    checks++;
    if (outValid !== '0 || inReady !== '0)
    begin
      $display("Mismatch at %0t: outValid,inReady expected 00000,00000, got %b,%b",
               $time, outValid, inReady);
      errors++;
    end
    rst <= 1'b0;
    cycles = 0;
    while (inReady !== {numPorts{1'b1}} && cycles < 10)
    begin
      @(posedge clk);
      cycles++;
      checks++;
      if (outValid !== '0)
      begin
        $display("Mismatch at %0t: outValid expected 00000, got %b", $time, outValid);
        errors++;
      end
    end
    if (inReady !== {numPorts{1'b1}})
    begin
      $display("inReady did not rise on all ports within 10 cycles of reset release");
      errors++;
    end
    testsRun++;
    $display("Test 1 reset state finished, %0d errors", errors - errorsBefore);
  endtask

  task automatic runTest(input int testNum, input string name);
    int cycles;
    int errorsBefore;
    errorsBefore = errors;
    curTest = testNum;
    prevStall = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      inIdx[p] = nextEntry(0, testNum, p, 1'b0);
      outIdx[p] = nextEntry(0, testNum, p, 1'b1);
    end
    if (!pending())
    begin
      $display("Test %0d has no flits in the stimulus file", testNum);
      errors++;
    end
    cycles = 0;
    while (pending() && cycles < 200)
    begin
      @(posedge clk);
      checkOutputs();
      driveInputs();
      cycles++;
    end
    if (pending())
    begin
      $display("Test %0d timed out after 200 cycles with flits still undelivered", testNum);
      errors++;
      for (int p = 0; p < numPorts; p++)
      begin
        inIdx[p] = -1;
        outIdx[p] = -1;
      end
    end
    inValid <= '0;
    outReady <= {numPorts{1'b1}};
    // A few idle cycles catch duplicated or late flits
    repeat (4)
    begin
      @(posedge clk);
      checkOutputs();
    end
    testsRun++;
    $display("Test %0d %s finished, %0d errors", testNum, name, errors - errorsBefore);
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    outReady = {numPorts{1'b1}};
    for (int p = 0; p < numPorts; p++)
    begin
      inFlit[p] = '0;
      inIdx[p] = -1;
      outIdx[p] = -1;
      prevFlit[p] = '0;
    end
    prevStall = '0;
    curTest = 0;
    errors = 0;
    checks = 0;
    testsRun = 0;
    randomBits = $urandom(68);
    readStim();

    repeat (3) @(posedge clk);
    checkReset();
    runTest(2, "xy routing");
    runTest(3, "packet order");
    runTest(4, "arbitration");
    runTest(5, "hold timeout");
    runTest(6, "back-pressure");

    $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
    if (errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
src/nocPkg.sv
src/flitQueue.sv
src/xyRoute.sv
src/holdTimer.sv
src/switchArbiter.sv
src/crossbar.sv
src/meshRouter.sv
testbench/routerTb.sv

//--- testbench/routerStim.txt
# test inPort destX destY kind length payload outPort
# ports 0 Local 1 North 2 East 3 West 4 South, kinds 0 head 1 body 2 tail
2 0 2 1 0 000 2001 2
2 1 1 2 0 000 2102 4
2 2 0 1 0 000 2203 3
2 3 1 0 0 000 2304 1
2 4 1 1 0 000 2405 0
3 3 3 2 0 000 3101 2
3 3 3 2 1 000 3102 2
3 3 3 2 1 000 3103 2
3 3 3 2 2 000 3104 2
4 0 1 3 0 000 4001 4
4 0 1 3 1 000 4002 4
4 0 1 3 2 000 4003 4
4 2 1 2 0 000 4201 4
4 2 1 2 2 000 4202 4
5 0 1 3 0 002 5001 4
5 0 1 3 1 000 5002 4
5 2 1 2 0 000 5201 4
5 2 1 2 2 000 5202 4
5 0 1 3 1 000 5003 4
5 0 1 3 2 000 5004 4
6 0 3 1 0 000 6001 2
6 0 3 1 1 000 6002 2
6 0 3 1 2 000 6003 2
6 4 1 0 0 000 6401 1
6 4 1 0 1 000 6402 1
6 4 1 0 2 000 6403 1
6 1 0 1 0 000 6101 3
6 1 0 2 2 000 6102 3
